//--- rtl/mips_int_config.svh
`ifndef MIPS_INT_CONFIG_SVH
`define MIPS_INT_CONFIG_SVH

// --------------------------------------------------
// Datapath sizes
// --------------------------------------------------
`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5
`define REG_COUNT       32
`define IMM_WIDTH       16

// --------------------------------------------------
// Opcodes, instr[31:26]
// --------------------------------------------------
`define OP_RTYPE  6'b000000
`define OP_ADDI   6'b001000
`define OP_ADDIU  6'b001001
`define OP_SLTI   6'b001010
`define OP_SLTIU  6'b001011
`define OP_ORI    6'b001101
`define OP_LUI    6'b001111

// R-type funct, instr[5:0]
`define FN_ADD   6'b100000
`define FN_ADDU  6'b100001
`define FN_SUB   6'b100010
`define FN_SUBU  6'b100011
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_SLT   6'b101010
`define FN_SLTU  6'b101011

`endif

//--- rtl/mips_int_pkg.sv
`default_nettype none

`include "mips_int_config.svh"

package mips_int_pkg;

	// Bit 2 selects inverted B with carry-in, bit 3 unsigned compare
	typedef enum logic [3:0] {
		alu_and  = 4'b0000,
		alu_or   = 4'b0001,
		alu_add  = 4'b0010,
		alu_sub  = 4'b0110,
		alu_slt  = 4'b0111,
		alu_sltu = 4'b1111
	} alu_op_t;

	// --------------------------------------------------
	// Stage payloads
	// --------------------------------------------------
	typedef struct packed {
		alu_op_t                    alu_op;
		logic                       use_imm;  // Operand B from imm
		logic [`DATA_WIDTH-1:0]     imm;      // Already extended or shifted
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rt;
		logic [`REG_ADDR_WIDTH-1:0] dest;
		logic [`DATA_WIDTH-1:0]     rs_val;
		logic [`DATA_WIDTH-1:0]     rt_val;
	} ex_req_t;

	typedef struct packed {
		logic [`REG_ADDR_WIDTH-1:0] dest;
		logic [`DATA_WIDTH-1:0]     data;
	} retire_t;

endpackage

`default_nettype wire

//--- rtl/instr_decoder.sv
`include "mips_int_config.svh"
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input  logic                       instr_valid,
	input  logic [`DATA_WIDTH-1:0]     instr,
	output logic [`REG_ADDR_WIDTH-1:0] rs_addr,
	output logic [`REG_ADDR_WIDTH-1:0] rt_addr,
	output logic                       dec_valid,
	output mips_int_pkg::ex_req_t      dec
);

	logic [5:0]             opcode;
	logic [5:0]             funct;
	logic [`IMM_WIDTH-1:0]  imm_field;
	logic [`DATA_WIDTH-1:0] imm_sext;
	logic [`DATA_WIDTH-1:0] imm_zext;
	logic [`DATA_WIDTH-1:0] imm_upper;
	logic                   supported;

	assign opcode    = instr[31:26];
	assign funct     = instr[5:0];
	assign imm_field = instr[`IMM_WIDTH-1:0];

	assign imm_sext  = {{(`DATA_WIDTH-`IMM_WIDTH){imm_field[`IMM_WIDTH-1]}}, imm_field};
	assign imm_zext  = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, imm_field};
	assign imm_upper = {imm_field, {(`DATA_WIDTH-`IMM_WIDTH){1'b0}}};  // LUI

	// LUI reads r0 so it can run as an OR
	assign rs_addr = (opcode == `OP_LUI) ? '0 : instr[25:21];
	assign rt_addr = instr[20:16];

	always_comb begin
		supported   = 1'b1;
		dec         = '0;
		dec.rs      = rs_addr;
		dec.rt      = rt_addr;
		dec.dest    = rt_addr;  // Immediate forms write rt
		dec.use_imm = 1'b1;
		dec.alu_op  = mips_int_pkg::alu_add;
		case (opcode)
			`OP_RTYPE: begin
				dec.use_imm = 1'b0;
				dec.dest    = instr[15:11];
				case (funct)
					`FN_ADD, `FN_ADDU: dec.alu_op = mips_int_pkg::alu_add;
					`FN_SUB, `FN_SUBU: dec.alu_op = mips_int_pkg::alu_sub;
					`FN_AND:           dec.alu_op = mips_int_pkg::alu_and;
					`FN_OR:            dec.alu_op = mips_int_pkg::alu_or;
					`FN_SLT:           dec.alu_op = mips_int_pkg::alu_slt;
					`FN_SLTU:          dec.alu_op = mips_int_pkg::alu_sltu;
					default:           supported  = 1'b0;  // JR and unknown funct
				endcase
			end
			`OP_ADDI, `OP_ADDIU: begin
				dec.alu_op = mips_int_pkg::alu_add;
				dec.imm    = imm_sext;
			end
			`OP_ORI: begin
				dec.alu_op = mips_int_pkg::alu_or;
				dec.imm    = imm_zext;
			end
			`OP_SLTI: begin
				dec.alu_op = mips_int_pkg::alu_slt;
				dec.imm    = imm_sext;
			end
			`OP_SLTIU: begin
				dec.alu_op = mips_int_pkg::alu_sltu;
				dec.imm    = imm_sext;  // Sign extended, compared unsigned
			end
			`OP_LUI: begin
				dec.alu_op = mips_int_pkg::alu_or;
				dec.imm    = imm_upper;
			end
			default: supported = 1'b0;  // Branch, jump, load, store
		endcase
	end

	assign dec_valid = instr_valid & supported;

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`include "mips_int_config.svh"
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`REG_ADDR_WIDTH-1:0] rs_addr,
	input  logic [`REG_ADDR_WIDTH-1:0] rt_addr,
	output logic [`DATA_WIDTH-1:0]     rs_data,
	output logic [`DATA_WIDTH-1:0]     rt_data,
	input  logic                       wr_en,
	input  logic [`REG_ADDR_WIDTH-1:0] wr_addr,
	input  logic [`DATA_WIDTH-1:0]     wr_data
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	// --------------------------------------------------
	// Write port
	// --------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin  // r0 never written
			regs[wr_addr] <= wr_data;
		end
	end

	// --------------------------------------------------
	// Read ports
	// --------------------------------------------------
	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

//--- rtl/pipe_stage.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// Payload follows input every cycle, qualified by out_valid
	always_ff @(posedge clk) begin
		out_data <= in_data;
	end

endmodule

`default_nettype wire

//--- rtl/alu_execute.sv
`include "mips_int_config.svh"
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
	input  mips_int_pkg::ex_req_t req,
	input  logic                  fwd_valid,
	input  mips_int_pkg::retire_t fwd,
	output mips_int_pkg::retire_t result
);

	logic                   fwd_rs;
	logic                   fwd_rt;
	logic [`DATA_WIDTH-1:0] op_a;
	logic [`DATA_WIDTH-1:0] rt_fwd;
	logic [`DATA_WIDTH-1:0] op_b;
	logic [`DATA_WIDTH-1:0] op_b_inv;
	logic                   invert_b;
	logic [`DATA_WIDTH:0]   sum_ext;
	logic                   carry;
	logic                   overflow;
	logic                   lt_signed;
	logic                   lt_unsigned;

	// --------------------------------------------------
	// Operand forwarding from the retire stage
	// --------------------------------------------------
	assign fwd_rs = fwd_valid && (fwd.dest != '0) && (fwd.dest == req.rs);
	assign fwd_rt = fwd_valid && (fwd.dest != '0) && (fwd.dest == req.rt);

	assign op_a   = fwd_rs ? fwd.data : req.rs_val;
	assign rt_fwd = fwd_rt ? fwd.data : req.rt_val;
	assign op_b   = req.use_imm ? req.imm : rt_fwd;

	// --------------------------------------------------
	// Shared adder for add, sub and compares
	// --------------------------------------------------
	assign invert_b = req.alu_op[2];
	assign op_b_inv = invert_b ? ~op_b : op_b;  // Subtract as a + ~b + 1
	assign sum_ext  = {1'b0, op_a} + {1'b0, op_b_inv} + {{`DATA_WIDTH{1'b0}}, invert_b};

	assign carry       = sum_ext[`DATA_WIDTH];
	assign overflow    = (op_a[`DATA_WIDTH-1] == op_b_inv[`DATA_WIDTH-1]) &&
	                     (sum_ext[`DATA_WIDTH-1] != op_a[`DATA_WIDTH-1]);
	assign lt_signed   = sum_ext[`DATA_WIDTH-1] ^ overflow;  // N xor V
	assign lt_unsigned = ~carry;                              // Borrow

	always_comb begin
		result.dest = req.dest;
		case (req.alu_op)
			mips_int_pkg::alu_add,
			mips_int_pkg::alu_sub:  result.data = sum_ext[`DATA_WIDTH-1:0];
			mips_int_pkg::alu_and:  result.data = op_a & op_b;
			mips_int_pkg::alu_or:   result.data = op_a | op_b;
			mips_int_pkg::alu_slt:  result.data = {{(`DATA_WIDTH-1){1'b0}}, lt_signed};
			mips_int_pkg::alu_sltu: result.data = {{(`DATA_WIDTH-1){1'b0}}, lt_unsigned};
			default:                result.data = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/mips_int_core.sv
`include "mips_int_config.svh"
`timescale 1ns/1ps
`default_nettype none

module mips_int_core (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       instr_valid,
	input  logic [`DATA_WIDTH-1:0]     instr,
	output logic                       retire_valid,
	output logic [`REG_ADDR_WIDTH-1:0] retire_reg,
	output logic [`DATA_WIDTH-1:0]     retire_data
);

	logic [`REG_ADDR_WIDTH-1:0] rs_addr;
	logic [`REG_ADDR_WIDTH-1:0] rt_addr;
	logic [`DATA_WIDTH-1:0]     rs_data;
	logic [`DATA_WIDTH-1:0]     rt_data;
	logic                       dec_valid;
	mips_int_pkg::ex_req_t      dec;
	mips_int_pkg::ex_req_t      issue_in;
	logic                       issue_valid;
	mips_int_pkg::ex_req_t      issue_req;
	mips_int_pkg::retire_t      ex_result;
	mips_int_pkg::retire_t      retire_out;

	// --------------------------------------------------
	// Decode and register read
	// --------------------------------------------------
	instr_decoder u_decoder (
		.instr_valid (instr_valid),
		.instr       (instr),
		.rs_addr     (rs_addr),
		.rt_addr     (rt_addr),
		.dec_valid   (dec_valid),
		.dec         (dec)
	);

	reg_file u_regs (
		.clk     (clk),
		.reset   (reset),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wr_en   (issue_valid),     // Write lands with the retire capture
		.wr_addr (ex_result.dest),
		.wr_data (ex_result.data)
	);

	assign issue_in = '{alu_op: dec.alu_op, use_imm: dec.use_imm, imm: dec.imm,
	                    rs: dec.rs, rt: dec.rt, dest: dec.dest,
	                    rs_val: rs_data, rt_val: rt_data};

	// --------------------------------------------------
	// Issue, execute, retire
	// --------------------------------------------------
	pipe_stage #(.payload_t(mips_int_pkg::ex_req_t)) u_issue (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (dec_valid),
		.in_data   (issue_in),
		.out_valid (issue_valid),
		.out_data  (issue_req)
	);

	alu_execute u_execute (
		.req       (issue_req),
		.fwd_valid (retire_valid),  // Only forwarding source
		.fwd       (retire_out),
		.result    (ex_result)
	);

	pipe_stage #(.payload_t(mips_int_pkg::retire_t)) u_retire (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (issue_valid),
		.in_data   (ex_result),
		.out_valid (retire_valid),
		.out_data  (retire_out)
	);

	assign retire_reg  = retire_out.dest;
	assign retire_data = retire_out.data;

endmodule

`default_nettype wire

//--- tb/retire_checker.sv
`include "mips_int_config.svh"
`timescale 1ns/1ps
`default_nettype none

module retire_checker (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       instr_valid,
	input  logic [`DATA_WIDTH-1:0]     instr,
	input  logic                       retire_valid,
	input  logic [`REG_ADDR_WIDTH-1:0] retire_reg,
	input  logic [`DATA_WIDTH-1:0]     retire_data,
	output int                         value_errors,
	output int                         protocol_errors,
	output int                         pending
);

	logic [`DATA_WIDTH-1:0]     shadow [`REG_COUNT];  // Registers in program order
	logic [`REG_ADDR_WIDTH-1:0] exp_reg [$];
	logic [`DATA_WIDTH-1:0]     exp_data [$];
	int                         exp_cycle [$];
	int                         cycle;
	logic [`REG_ADDR_WIDTH-1:0] pred_reg;
	logic [`DATA_WIDTH-1:0]     pred_data;
	logic [`REG_ADDR_WIDTH-1:0] head_reg;
	logic [`DATA_WIDTH-1:0]     head_data;
	int                         head_cycle;

	// Returns 0 for encodings that must never retire
	function automatic logic predict(input logic [`DATA_WIDTH-1:0] word,
	                                 output logic [`REG_ADDR_WIDTH-1:0] dest,
	                                 output logic [`DATA_WIDTH-1:0] data);
		logic [`DATA_WIDTH-1:0] a;
		logic [`DATA_WIDTH-1:0] b;
		logic [`DATA_WIDTH-1:0] sext;
		logic                   known;
		a     = shadow[word[25:21]];
		b     = shadow[word[20:16]];
		sext  = {{16{word[15]}}, word[15:0]};
		known = 1'b1;
		dest  = word[20:16];
		data  = '0;
		case (word[31:26])
			`OP_RTYPE: begin
				dest = word[15:11];
				case (word[5:0])
					`FN_ADD, `FN_ADDU: data = a + b;
					`FN_SUB, `FN_SUBU: data = a - b;
					`FN_AND:           data = a & b;
					`FN_OR:            data = a | b;
					`FN_SLT:           data = ($signed(a) < $signed(b)) ? 1 : 0;
					`FN_SLTU:          data = (a < b) ? 1 : 0;
					default:           known = 1'b0;
				endcase
			end
			`OP_ADDI, `OP_ADDIU: data = a + sext;
			`OP_SLTI:            data = ($signed(a) < $signed(sext)) ? 1 : 0;
			`OP_SLTIU:           data = (a < sext) ? 1 : 0;
			`OP_ORI:             data = a | {16'h0000, word[15:0]};
			`OP_LUI:             data = {word[15:0], 16'h0000};
			default:             known = 1'b0;
		endcase
		return known;
	endfunction

	initial begin
		value_errors    = 0;
		protocol_errors = 0;
		pending         = 0;
	end

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			cycle   = 0;
			pending = 0;
			exp_reg.delete();
			exp_data.delete();
			exp_cycle.delete();
			for (int i = 0; i < `REG_COUNT; i++) begin
				shadow[i] = '0;
			end
		end else begin
			cycle = cycle + 1;
			if (retire_valid) begin
				if (exp_reg.size() == 0) begin
					$display("Retirement of r%0d at %0t with no instruction outstanding",
					         retire_reg, $time);
					protocol_errors++;
				end else begin
					head_reg   = exp_reg.pop_front();
					head_data  = exp_data.pop_front();
					head_cycle = exp_cycle.pop_front();
					if (cycle - head_cycle != 2) begin
						$display("Retirement at %0t came %0d cycles after acceptance, not 2",
						         $time, cycle - head_cycle);
						protocol_errors++;
					end
					if (retire_reg !== head_reg || retire_data !== head_data) begin
						$display("[ERROR] %0t: retired r%0d = %h, expected r%0d = %h",
						         $time, retire_reg, retire_data, head_reg, head_data);
						value_errors++;
					end
				end
			end else if (exp_cycle.size() != 0 && cycle - exp_cycle[0] >= 2) begin
				$display("Instruction accepted in cycle %0d did not retire on time",
				         exp_cycle[0]);
				protocol_errors++;
				head_reg   = exp_reg.pop_front();
				head_data  = exp_data.pop_front();
				head_cycle = exp_cycle.pop_front();
			end
			if (instr_valid && predict(instr, pred_reg, pred_data)) begin
				exp_reg.push_back(pred_reg);
				exp_data.push_back(pred_data);
				exp_cycle.push_back(cycle);
				if (pred_reg != '0) begin
					shadow[pred_reg] = pred_data;  // r0 stays zero
				end
			end
			pending = exp_reg.size();
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_mips_int_core.sv
`include "mips_int_config.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_mips_int_core;

	localparam int RANDOM_COUNT = 400;
	localparam int DRAIN_LIMIT  = 50;

	logic                       clk;
	logic                       reset;
	logic                       instr_valid;
	logic [`DATA_WIDTH-1:0]     instr;
	logic                       retire_valid;
	logic [`REG_ADDR_WIDTH-1:0] retire_reg;
	logic [`DATA_WIDTH-1:0]     retire_data;
	int                         value_errors;
	int                         protocol_errors;
	int                         pending;
	int unsigned                seed_value;
	int                         wait_cycles;
	logic [31:0]                gap;

	mips_int_core u_dut (
		.clk          (clk),
		.reset        (reset),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.retire_valid (retire_valid),
		.retire_reg   (retire_reg),
		.retire_data  (retire_data)
	);

	retire_checker u_checker (
		.clk             (clk),
		.reset           (reset),
		.instr_valid     (instr_valid),
		.instr           (instr),
		.retire_valid    (retire_valid),
		.retire_reg      (retire_reg),
		.retire_data     (retire_data),
		.value_errors    (value_errors),
		.protocol_errors (protocol_errors),
		.pending         (pending)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [`DATA_WIDTH-1:0] encode_rtype(input logic [5:0] funct,
	                                                        input logic [4:0] rd,
	                                                        input logic [4:0] rs,
	                                                        input logic [4:0] rt);
		return {`OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [`DATA_WIDTH-1:0] encode_itype(input logic [5:0] opcode,
	                                                        input logic [4:0] rt,
	                                                        input logic [4:0] rs,
	                                                        input logic [15:0] imm);
		return {opcode, rs, rt, imm};
	endfunction

	function automatic logic [`DATA_WIDTH-1:0] random_instr();
		logic [31:0] word;
		logic [31:0] pick;
		word        = $urandom;
		pick        = $urandom;
		word[25:21] = {2'b00, pick[2:0]};  // Small register pool
		word[20:16] = {2'b00, pick[5:3]};
		case (pick[9:7])
			3'd0, 3'd1, 3'd2: begin
				word[31:26] = `OP_RTYPE;
				word[15:11] = {2'b00, pick[12:10]};
				word[5:4]   = 2'b10;  // Mostly ALU funct, some unknown
			end
			3'd3, 3'd4, 3'd5: word[31:29] = 3'b001;  // Immediate group incl. ANDI, XORI
			3'd6:             word[31:26] = `OP_RTYPE;  // Any funct, JR among them
			default: ;  // Any opcode, branch, jump, load and store
		endcase
		return word;
	endfunction

	task automatic issue(input logic [`DATA_WIDTH-1:0] word);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= word;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			instr_valid <= 1'b0;
			instr       <= $urandom;  // Ignored without strobe
		end
	endtask

	initial begin
		seed_value  = $urandom(37176);
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// --------------------------------------------------
		// Directed prologue
		// --------------------------------------------------
		issue(encode_itype(`OP_ADDI, 5'd1, 5'd0, 16'hffff));
		issue(encode_itype(`OP_LUI, 5'd2, 5'd0, 16'h8000));
		issue(encode_itype(`OP_LUI, 5'd3, 5'd0, 16'h7fff));
		issue(encode_itype(`OP_ORI, 5'd3, 5'd3, 16'hffff));  // Distance one
		issue(encode_itype(`OP_ADDI, 5'd4, 5'd0, 16'h0001));
		issue(encode_itype(`OP_ADDIU, 5'd5, 5'd0, 16'h8000));
		issue(encode_itype(`OP_SLTIU, 5'd6, 5'd0, 16'hffff));
		issue(encode_itype(`OP_ADDI, 5'd0, 5'd4, 16'h0005));  // r0 write
		issue(encode_rtype(`FN_ADD, 5'd7, 5'd0, 5'd0));
		issue(encode_rtype(`FN_SLT, 5'd8, 5'd2, 5'd3));
		issue(encode_rtype(`FN_SLTU, 5'd9, 5'd2, 5'd3));
		issue(encode_rtype(`FN_SUB, 5'd10, 5'd2, 5'd4));
		issue(encode_itype(`OP_SLTI, 5'd11, 5'd2, 16'h0000));
		issue(32'h1022_0004);  // beq
		issue(32'h0800_0010);  // j
		issue(32'h03e0_0008);  // jr
		issue(32'h8c22_0000);  // lw into r2
		issue(32'hac23_0000);  // sw
		issue(encode_rtype(`FN_OR, 5'd12, 5'd2, 5'd8));
		idle(3);

		// --------------------------------------------------
		// Random runs and drain
		// --------------------------------------------------
		for (int n = 0; n < RANDOM_COUNT; n++) begin
			gap = $urandom;
			if (gap[1:0] == 2'b00) begin
				idle(1 + gap[3:2]);
			end
			issue(random_instr());
		end
		idle(20);

		wait_cycles = 0;
		while (pending != 0 && wait_cycles < DRAIN_LIMIT) begin
			@(negedge clk);
			wait_cycles++;
		end
		@(negedge clk);
		if (pending != 0) begin
			$display("Timeout after drain, %0d instructions never retired", pending);
		end
		$display("Errors: %0d value, %0d protocol, %0d outstanding",
		         value_errors, protocol_errors, pending);
		if (value_errors == 0 && protocol_errors == 0 && pending == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- mips_int_core.f
+incdir+rtl
rtl/mips_int_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/pipe_stage.sv
rtl/alu_execute.sv
rtl/mips_int_core.sv
tb/retire_checker.sv
tb/tb_mips_int_core.sv
